//--- cache_subsystem.f
hw/cache_pkg.sv
hw/cache_select_regs.sv
hw/dcache.sv
hw/data_memory.sv
hw/cache_controller.sv
hw/cache_subsystem.sv
tb/cache_subsystem_asserts.sv
tb/cache_checker.sv
tb/tb_cache_subsystem.sv

//--- hw/cache_controller.sv
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  cache_sel_t  cache_select,
    input  logic        read,
    input  logic        write,
    input  addr_t       address,
    input  word_t       writedata,
    output word_t       readdata,
    output logic        busywait,
    output logic        mem_read,
    output logic        mem_write,
    output block_addr_t mem_address,
    output block_t      mem_writedata,
    input  block_t      mem_readdata,
    input  logic        mem_busywait
);

    logic [1:0]            active_cache;
    logic [NUM_CACHES-1:0] cache_enable;

    word_t       cache_readdata      [NUM_CACHES];
    logic        cache_busywait      [NUM_CACHES];
    logic        cache_mem_read      [NUM_CACHES];
    logic        cache_mem_write     [NUM_CACHES];
    block_addr_t cache_mem_address   [NUM_CACHES];
    block_t      cache_mem_writedata [NUM_CACHES];

    // 1 to 3 pick caches 1 to 3, anything else falls to cache 4
    always_comb begin
        case (cache_select)
            3'd1:    active_cache = 2'd0;
            3'd2:    active_cache = 2'd1;
            3'd3:    active_cache = 2'd2;
            default: active_cache = 2'd3;
        endcase
    end

    assign cache_enable = NUM_CACHES'(1) << active_cache;

    for (genvar i = 0; i < NUM_CACHES; i++) begin : g_cache
        dcache u_dcache (
            .clock         (clock),
            .reset         (reset),
            .read          (read & cache_enable[i]),
            .write         (write & cache_enable[i]),
            .address       (address),
            .writedata     (writedata),
            .readdata      (cache_readdata[i]),
            .busywait      (cache_busywait[i]),
            .mem_read      (cache_mem_read[i]),
            .mem_write     (cache_mem_write[i]),
            .mem_address   (cache_mem_address[i]),
            .mem_writedata (cache_mem_writedata[i]),
            .mem_readdata  (mem_readdata),
            .mem_busywait  (mem_busywait & cache_enable[i])
        );
    end

    // return path and memory port follow the active cache
    assign readdata      = cache_readdata[active_cache];
    assign busywait      = cache_busywait[active_cache];
    assign mem_read      = cache_mem_read[active_cache];
    assign mem_write     = cache_mem_write[active_cache];
    assign mem_address   = cache_mem_address[active_cache];
    assign mem_writedata = cache_mem_writedata[active_cache];

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

    // widths that carry a meaning
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [27:0]  block_addr_t;
    typedef logic [2:0]   cache_sel_t;
    typedef logic [24:0]  tag_t;
    typedef logic [2:0]   index_t;

    // miss handling states of one cache
    typedef enum logic [1:0] {
        idle,
        write_back,
        allocate
    } cache_state_t;

    // cache geometry
    localparam int NUM_CACHES = 4;
    localparam int NUM_LINES  = 8;

    // backing memory
    localparam int MEM_DEPTH   = 256;
    localparam int MEM_LATENCY = 4;

    // register map
    localparam addr_t SEL_REG_OFFSET = 32'h0000_0000;

endpackage

//--- hw/cache_select_regs.sv
`timescale 1ns/1ps

module cache_select_regs import cache_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  addr_t      paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic       cache_busy,
    output cache_sel_t cache_select
);

    logic access;
    logic addr_ok;

    assign access  = psel & penable;
    assign addr_ok = (paddr == SEL_REG_OFFSET);

    // access phase is stretched until the active cache goes idle
    assign pready  = access & ~cache_busy;
    assign pslverr = pready & ~addr_ok;

    // readback, zero for unmapped offsets
    assign prdata = (access && !pwrite && addr_ok) ? word_t'(cache_select) : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cache_select <= '0;
        end else if (pready && pwrite && addr_ok) begin
            cache_select <= pwdata[$bits(cache_sel_t)-1:0];
        end
    end

endmodule

//--- hw/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  word_t pwdata,
    output word_t prdata,
    output logic  pready,
    output logic  pslverr,
    input  logic  read,
    input  logic  write,
    input  addr_t address,
    input  word_t writedata,
    output word_t readdata,
    output logic  busywait
);

    cache_sel_t  cache_select;
    logic        mem_read;
    logic        mem_write;
    block_addr_t mem_address;
    block_t      mem_writedata;
    block_t      mem_readdata;
    logic        mem_busywait;

    // busywait of the active cache doubles as APB back-pressure
    cache_select_regs u_regs (
        .clock        (clock),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .cache_busy   (busywait),
        .cache_select (cache_select)
    );

    cache_controller u_controller (
        .clock         (clock),
        .reset         (reset),
        .cache_select  (cache_select),
        .read          (read),
        .write         (write),
        .address       (address),
        .writedata     (writedata),
        .readdata      (readdata),
        .busywait      (busywait),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_writedata (mem_writedata),
        .mem_readdata  (mem_readdata),
        .mem_busywait  (mem_busywait)
    );

    data_memory u_memory (
        .clock         (clock),
        .reset         (reset),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_writedata (mem_writedata),
        .mem_readdata  (mem_readdata),
        .mem_busywait  (mem_busywait)
    );

endmodule

//--- hw/data_memory.sv
`timescale 1ns/1ps

module data_memory import cache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        mem_read,
    input  logic        mem_write,
    input  block_addr_t mem_address,
    input  block_t      mem_writedata,
    output block_t      mem_readdata,
    output logic        mem_busywait
);

    block_t memory [MEM_DEPTH];

    logic [$clog2(MEM_LATENCY+1)-1:0] count;
    logic [$clog2(MEM_DEPTH)-1:0]     mem_index;
    logic                             active;
    logic                             done;

    // upper block address bits fall outside the array
    assign mem_index = mem_address[$clog2(MEM_DEPTH)-1:0];
    assign active    = mem_read | mem_write;
    assign done      = active && (count == MEM_LATENCY);

    // busy from the first request cycle until the count ends
    assign mem_busywait = active && !done;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                memory[i] <= '0;
            end
        end else if (done) begin
            count <= '0;
            if (mem_write) begin
                memory[mem_index] <= mem_writedata;
            end
        end else if (active) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    // read data lands for the single ready cycle
    always_ff @(posedge clock) begin
        if (mem_read && count == MEM_LATENCY - 1) begin
            mem_readdata <= memory[mem_index];
        end
    end

endmodule

//--- hw/dcache.sv
`timescale 1ns/1ps

module dcache import cache_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        read,
    input  logic        write,
    input  addr_t       address,
    input  word_t       writedata,
    output word_t       readdata,
    output logic        busywait,
    output logic        mem_read,
    output logic        mem_write,
    output block_addr_t mem_address,
    output block_t      mem_writedata,
    input  block_t      mem_readdata,
    input  logic        mem_busywait
);

    // line storage
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;
    tag_t                 tags   [NUM_LINES];
    block_t               blocks [NUM_LINES];

    cache_state_t state;

    tag_t       line_tag;
    index_t     line_index;
    logic [1:0] word_sel;
    logic       request;
    logic       hit;

    assign line_tag   = address[31:7];
    assign line_index = address[6:4];
    assign word_sel   = address[3:2];
    assign request    = read | write;

    assign hit = valid[line_index] && (tags[line_index] == line_tag);

    // hit data comes straight out of the line
    assign readdata = blocks[line_index][word_sel*32 +: 32];

    // held high for the whole miss, even if the request drops
    assign busywait = (state != idle) || (request && !hit);

    assign mem_read      = (state == allocate);
    assign mem_write     = (state == write_back);
    assign mem_writedata = blocks[line_index];

    // victim address on write back, requested block on allocate
    always_comb begin
        if (state == write_back) begin
            mem_address = {tags[line_index], line_index};
        end else begin
            mem_address = {line_tag, line_index};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
            valid <= '0;
            dirty <= '0;
        end else begin
            case (state)
                idle: begin
                    if (write && hit) begin
                        dirty[line_index] <= 1'b1;
                    end else if (request && !hit) begin
                        if (valid[line_index] && dirty[line_index]) begin
                            state <= write_back;
                        end else begin
                            state <= allocate;
                        end
                    end
                end
                write_back: begin
                    if (!mem_busywait) begin
                        state <= allocate;
                    end
                end
                allocate: begin
                    if (!mem_busywait) begin
                        valid[line_index] <= 1'b1;
                        dirty[line_index] <= 1'b0;
                        state             <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // tag and data arrays
    always_ff @(posedge clock) begin
        if (state == allocate && !mem_busywait) begin
            tags[line_index]   <= line_tag;
            blocks[line_index] <= mem_readdata;
        end else if (state == idle && write && hit) begin
            blocks[line_index][word_sel*32 +: 32] <= writedata;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_subsystem \
    -f cache_subsystem.f \
    -o sim_cache_subsystem

./obj_dir/sim_cache_subsystem | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb/cache_cases.txt
# op arg data expected, all hex
# S select write, G select readback, B bad offset write, W store, L load, P load with select write
G 0 0 0
S 1 0 0
G 0 0 1
S 2 0 0
G 0 0 2
S 3 0 0
G 0 0 3
S 6 0 0
G 0 0 6
B 4 5 1
G 0 0 6
S 1 0 0
W 00000040 11111111 0
L 00000040 0 11111111
L 00000044 0 0
L 0000004C 0 0
S 2 0 0
L 00000040 0 0
S 1 0 0
L 00000040 0 11111111
W 00000020 22222222 0
W 000000A0 33333333 0
S 2 0 0
L 00000020 0 22222222
S 0 0 0
W 00000040 44444444 0
S 7 0 0
L 00000040 0 44444444
S 3 0 0
L 00000040 0 0
P 00000020 1 22222222
L 000000A0 0 33333333
L 00000020 0 22222222
S 2 0 0
L 000000A0 0 33333333

//--- tb/cache_checker.sv
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  int         case_index,
    input  logic [7:0] case_op,
    input  word_t      expected,
    input  logic       psel,
    input  logic       penable,
    input  logic       pready,
    input  logic       pslverr,
    input  word_t      prdata,
    input  logic       read,
    input  logic       write,
    input  logic       busywait,
    input  word_t      readdata,
    output int         pass_count,
    output int         fail_count
);

    logic  apb_done;
    logic  load_done;
    logic  store_done;
    logic  load_seen;
    word_t load_value;

    // completion edges of both handshakes
    assign apb_done   = psel & penable & pready;
    assign load_done  = read & ~busywait;
    assign store_done = write & ~busywait;

    task automatic record_pass();
        pass_count++;
        $display("case %0d (%c) passed", case_index, case_op);
    endtask

    task automatic record_fail(input string msg);
        fail_count++;
        $display("Error at %0d ns: case %0d (%c) %s", $time, case_index, case_op, msg);
    endtask

    task automatic check_apb();
        case (case_op)
            "S": begin
                if (pslverr) begin
                    record_fail("select write answered with pslverr");
                end else begin
                    record_pass();
                end
            end
            "G": begin
                if (pslverr || prdata != expected) begin
                    record_fail($sformatf("readback %h err %b, expected %h", prdata, pslverr,
                                          expected));
                end else begin
                    record_pass();
                end
            end
            "B": begin
                if (pslverr != expected[0] || prdata != '0) begin
                    record_fail($sformatf("bad offset gave pslverr %b prdata %h", pslverr,
                                          prdata));
                end else begin
                    record_pass();
                end
            end
            "P": begin
                // select write must wait for the pending miss
                if (!load_seen) begin
                    record_fail("select write completed while the load was still pending");
                end else if (load_value != expected) begin
                    record_fail($sformatf("load returned %h, expected %h", load_value,
                                          expected));
                end else if (pslverr) begin
                    record_fail("select write answered with pslverr");
                end else begin
                    record_pass();
                end
                load_seen = 1'b0;
            end
            default: begin
                record_fail("unexpected APB access");
            end
        endcase
    endtask

    always @(posedge clock) begin
        if (reset) begin
            pass_count = 0;
            fail_count = 0;
            load_seen  = 1'b0;
            load_value = '0;
        end else begin
            if (load_done && case_op == "L") begin
                if (readdata == expected) begin
                    record_pass();
                end else begin
                    record_fail($sformatf("load returned %h, expected %h", readdata, expected));
                end
            end
            if (load_done && case_op == "P") begin
                load_seen  = 1'b1;
                load_value = readdata;
            end
            if (store_done && case_op == "W") begin
                record_pass();
            end
            // load handled first so a same-edge finish counts as ordered
            if (apb_done) begin
                check_apb();
            end
        end
    end

endmodule

//--- tb/cache_subsystem_asserts.sv
`timescale 1ns/1ps

module cache_subsystem_asserts import cache_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  psel,
    input logic  penable,
    input logic  pready,
    input logic  pslverr,
    input logic  read,
    input logic  write,
    input logic  busywait,
    input addr_t address,
    input logic  mem_read,
    input logic  mem_write
);

    int failures = 0;

    busy_low_in_reset: assert property (@(posedge clock) reset |-> !busywait)
        else begin
            failures++;
            $error("busywait high during reset");
        end

    mem_one_request: assert property (@(posedge clock) disable iff (reset)
        !(mem_read && mem_write))
        else begin
            failures++;
            $error("mem_read and mem_write high together");
        end

    slverr_in_access: assert property (@(posedge clock) disable iff (reset)
        pslverr |-> (psel && penable && pready))
        else begin
            failures++;
            $error("pslverr outside a completing access phase");
        end

    // cpu holds the address until the access completes
    address_held: assert property (@(posedge clock) disable iff (reset)
        ((read || write) && busywait) |=> $stable(address))
        else begin
            failures++;
            $error("address changed while busywait was high");
        end

endmodule

bind cache_subsystem cache_subsystem_asserts u_asserts (
    .clock     (clock),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .read      (read),
    .write     (write),
    .busywait  (busywait),
    .address   (address),
    .mem_read  (mem_read),
    .mem_write (mem_write)
);

//--- tb/tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem import cache_pkg::*; ();

    localparam int MAX_CASES       = 64;
    localparam int CYCLES_PER_CASE = 20;

    logic  clock;
    logic  reset;
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;
    logic  read;
    logic  write;
    addr_t address;
    word_t writedata;
    word_t readdata;
    logic  busywait;

    // case table
    logic [7:0] case_ops    [MAX_CASES];
    word_t      case_args   [MAX_CASES];
    word_t      case_data   [MAX_CASES];
    word_t      case_expect [MAX_CASES];
    int         num_cases;
    logic       file_ok;

    int         current_case;
    logic [7:0] current_op;
    word_t      current_expect;
    int         pass_count;
    int         fail_count;
    int         cycle_count;
    int         cycle_limit;

    cache_subsystem u_dut (
        .clock     (clock),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .read      (read),
        .write     (write),
        .address   (address),
        .writedata (writedata),
        .readdata  (readdata),
        .busywait  (busywait)
    );

    cache_checker u_checker (
        .clock      (clock),
        .reset      (reset),
        .case_index (current_case),
        .case_op    (current_op),
        .expected   (current_expect),
        .psel       (psel),
        .penable    (penable),
        .pready     (pready),
        .pslverr    (pslverr),
        .prdata     (prdata),
        .read       (read),
        .write      (write),
        .busywait   (busywait),
        .readdata   (readdata),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic load_cases();
        int         fd;
        int         code;
        int         fields;
        string      line;
        logic [7:0] op;
        word_t      arg;
        word_t      dat;
        word_t      expv;
        num_cases = 0;
        fd = $fopen("tb/cache_cases.txt", "r");
        file_ok = (fd != 0);
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                code = $fgets(line, fd);
                // comment lines fail to parse and are skipped
                fields = $sscanf(line, "%c %h %h %h", op, arg, dat, expv);
                if (code > 0 && fields == 4) begin
                    case_ops[num_cases]    = op;
                    case_args[num_cases]   = arg;
                    case_data[num_cases]   = dat;
                    case_expect[num_cases] = expv;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // setup phase, then access phase held until pready
    task automatic apb_access(input addr_t addr, input logic wr, input word_t data);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(posedge clock);
        while (!pready) begin
            @(posedge clock);
        end
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic cpu_access(input logic rd, input addr_t addr, input word_t data);
        read      = rd;
        write     = !rd;
        address   = addr;
        writedata = data;
        @(posedge clock);
        while (busywait) begin
            @(posedge clock);
        end
        #1;
        read  = 1'b0;
        write = 1'b0;
    endtask

    task automatic run_case(input int idx);
        current_case   = idx;
        current_op     = case_ops[idx];
        current_expect = case_expect[idx];
        case (case_ops[idx])
            "S": apb_access(SEL_REG_OFFSET, 1'b1, case_args[idx]);
            "G": apb_access(SEL_REG_OFFSET, 1'b0, '0);
            "B": apb_access(case_args[idx], 1'b1, case_data[idx]);
            "W": cpu_access(1'b0, case_args[idx], case_data[idx]);
            "L": cpu_access(1'b1, case_args[idx], '0);
            "P": begin
                // select write lands in the middle of the load miss
                fork
                    cpu_access(1'b1, case_args[idx], '0);
                    begin
                        @(posedge clock);
                        #1;
                        apb_access(SEL_REG_OFFSET, 1'b1, case_data[idx]);
                    end
                join
            end
            default: $display("case %0d has an unknown operation %c", idx, case_ops[idx]);
        endcase
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        read           = 1'b0;
        write          = 1'b0;
        address        = '0;
        writedata      = '0;
        current_case   = 0;
        current_op     = 8'h00;
        current_expect = '0;
        cycle_count    = 0;
        load_cases();
        cycle_limit = num_cases * CYCLES_PER_CASE + 100;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        repeat (2) @(posedge clock);
        $display("%0d cases passed, %0d failed", pass_count, fail_count);
        if (file_ok && num_cases > 0 && fail_count == 0 && pass_count == num_cases &&
            u_dut.u_asserts.failures == 0) begin
            $display("TEST OK");
        end else begin
            if (!file_ok || num_cases == 0) begin
                $display("the case file could not be read");
            end else if (pass_count + fail_count != num_cases) begin
                $display("some cases finished without a result");
            end
            if (u_dut.u_asserts.failures != 0) begin
                $display("%0d protocol assertions failed", u_dut.u_asserts.failures);
            end
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
